//--- source/irq_pkg.sv
// Machine mode only; fixed 32-line map where 31..16, 11, 7 and 3 exist and all else is reserved
`default_nettype none

package irq_pkg;

  // ------------------------------------------------------------
  // Interrupt line map
  // ------------------------------------------------------------

  // One bit per line in MIP and MIE
  localparam int unsigned NUM_IRQ = 32;

  // Implemented lines: 31..16 fast, 11 external, 7 timer, 3 software
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  // Line numbers used by the priority rule
  localparam int unsigned IRQ_FAST_LO = 16;
  localparam int unsigned IRQ_FAST_HI = 31;
  localparam int unsigned IRQ_EXT     = 11;
  localparam int unsigned IRQ_SOFT    = 3;
  localparam int unsigned IRQ_TIMER   = 7;

  // ------------------------------------------------------------
  // Instruction encodings
  // ------------------------------------------------------------

  // Standard WFI
  localparam logic [31:0] WFI_INSTR = 32'h1050_0073;
  // Custom wait-for-event
  localparam logic [31:0] WFE_INSTR = 32'h8c00_0073;

  // Global enable position inside MSTATUS
  localparam int unsigned MSTATUS_MIE_BIT = 3;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  typedef logic [NUM_IRQ-1:0] irq_vec_t;
  typedef logic [4:0]         irq_id_t;
  typedef logic [31:0]        instr_t;
  typedef logic [3:0]         wb_adr_t;
  typedef logic [31:0]        wb_data_t;

  // Register port byte addresses
  localparam wb_adr_t ADR_MIE     = 4'h0;
  localparam wb_adr_t ADR_MSTATUS = 4'h4;
  localparam wb_adr_t ADR_MIP     = 4'h8;

endpackage

`default_nettype wire

//--- source/irq_csr_regs.sv
// Full-word Wishbone classic access only, no stall, unknown addresses read zero and drop writes
`timescale 1ns/1ps
`default_nettype none

module irq_csr_regs import irq_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  // Wishbone classic slave
  input  wire logic     wb_cyc_i,
  input  wire logic     wb_stb_i,
  input  wire logic     wb_we_i,
  input  wire wb_adr_t  wb_adr_i,
  input  wire wb_data_t wb_dat_i,
  output wb_data_t      wb_dat_o,
  output logic          wb_ack_o,
  // Interrupt side
  input  wire irq_vec_t irq_i,
  input  wire logic     irq_ack_i,
  output irq_vec_t      mip_o,
  output irq_vec_t      mie_o,
  output logic          mstatus_mie_o
);

  // ------------------------------------------------------------
  // Bus decode
  // ------------------------------------------------------------

  // New access seen, held off in the cycle right after an ack
  logic bus_req;
  logic wr_mie;
  logic wr_mstatus;
  wb_data_t rd_word;
  // Stored global enable, the output also drops while an ack is shown
  logic mstatus_mie_q;

  assign bus_req    = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_mie     = bus_req && wb_we_i && (wb_adr_i == ADR_MIE);
  assign wr_mstatus = bus_req && wb_we_i && (wb_adr_i == ADR_MSTATUS);

  // Enable is seen clear from the edge that raises the ack
  assign mstatus_mie_o = mstatus_mie_q && !irq_ack_i;

  // Read mux, MSTATUS shows only the global enable
  always_comb begin
    rd_word = '0;
    case (wb_adr_i)
      ADR_MIE:     rd_word = mie_o;
      ADR_MSTATUS: rd_word[MSTATUS_MIE_BIT] = mstatus_mie_o;
      ADR_MIP:     rd_word = mip_o;
      default:     rd_word = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o      <= 1'b0;
      mie_o         <= '0;
      mstatus_mie_q <= 1'b0;
      mip_o         <= '0;
    end else begin
      wb_ack_o <= bus_req;
      // Pending lines follow the inputs one cycle late
      mip_o    <= irq_i & VALID_IRQ_MASK;
      if (wr_mie) begin
        mie_o <= wb_dat_i & VALID_IRQ_MASK;
      end
      // Taking an interrupt beats a software write
      if (irq_ack_i) begin
        mstatus_mie_q <= 1'b0;
      end else if (wr_mstatus) begin
        mstatus_mie_q <= wb_dat_i[MSTATUS_MIE_BIT];
      end
    end
  end

  // Read data is sampled with the request and shown during ack
  always_ff @(posedge clk_i) begin
    if (bus_req) begin
      wb_dat_o <= rd_word;
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------

  // No back-to-back acks, master must see a gap
  a_ack_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o);

  // Reserved lines never reach MIP
  a_mip_reserved: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mip_o & ~VALID_IRQ_MASK) == '0);

endmodule

`default_nettype wire

//--- source/irq_arbiter.sv
// Fixed priority 31..16, 11, 3, 7; no queue, winner recomputed every cycle while irq_ready_i is low
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter import irq_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire irq_vec_t mip_i,
  input  wire irq_vec_t mie_i,
  input  wire logic     mstatus_mie_i,
  input  wire logic     irq_ready_i,
  output logic          irq_ack_o,
  output irq_id_t       irq_id_o,
  output logic          irq_wake_o
);

  // ------------------------------------------------------------
  // Selection
  // ------------------------------------------------------------
  irq_vec_t pend_en;
  logic     win_valid;
  irq_id_t  win_id;
  logic     take;

  assign pend_en = mip_i & mie_i;

  // Wake ignores the global enable
  assign irq_wake_o = |pend_en;

  // Lowest priority first, later hits override
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pend_en[IRQ_TIMER]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(IRQ_TIMER);
    end
    if (pend_en[IRQ_SOFT]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(IRQ_SOFT);
    end
    if (pend_en[IRQ_EXT]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(IRQ_EXT);
    end
    // Fast lines, highest number wins
    for (int i = IRQ_FAST_LO; i <= IRQ_FAST_HI; i++) begin
      if (pend_en[i]) begin
        win_valid = 1'b1;
        win_id    = irq_id_t'(i);
      end
    end
  end

  assign take = win_valid && mstatus_mie_i && irq_ready_i;

  // ------------------------------------------------------------
  // Acknowledge
  // ------------------------------------------------------------

  // Pulse ends because the register block drops the global enable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_ack_o <= 1'b0;
    end else begin
      irq_ack_o <= take;
    end
  end

  // Id only meaningful alongside the ack
  always_ff @(posedge clk_i) begin
    irq_id_o <= win_id;
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o);

  a_id_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> VALID_IRQ_MASK[irq_id_o]);

  a_id_enabled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> mie_i[irq_id_o]);

endmodule

`default_nettype wire

//--- source/sleep_ctrl.sv
// Sleeps only after a clean WFI/WFE retires and the pipeline drains; wake needs irq_wake_i or debug_req_i
`timescale 1ns/1ps
`default_nettype none

module sleep_ctrl import irq_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Retirement stage
  input  wire logic       wb_instr_valid_i,
  input  wire instr_t     wb_instr_rdata_i,
  input  wire logic       wb_instr_err_i,
  input  wire logic       wb_kill_i,
  // Debug
  input  wire logic       debug_mode_i,
  input  wire logic       debug_req_i,
  // Pipeline activity
  input  wire logic       lsu_busy_i,
  input  wire logic [1:0] alignbuf_outstanding_i,
  // Pending enabled interrupt from the arbiter
  input  wire logic       irq_wake_i,
  output logic            core_sleep_o
);

  // ------------------------------------------------------------
  // Retirement detection
  // ------------------------------------------------------------
  logic is_wait_op;
  logic wait_retire;
  logic wake;
  logic pipe_idle;
  logic in_wait_q;

  assign is_wait_op = (wb_instr_rdata_i == WFI_INSTR) || (wb_instr_rdata_i == WFE_INSTR);

  // Errored, killed or debug-mode instances are ignored
  assign wait_retire = wb_instr_valid_i && is_wait_op &&
                       !wb_instr_err_i && !wb_kill_i && !debug_mode_i;

  assign wake      = irq_wake_i || debug_req_i;
  assign pipe_idle = (alignbuf_outstanding_i == 2'd0) && !lsu_busy_i;

  // ------------------------------------------------------------
  // Wait state and sleep output
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_wait_q    <= 1'b0;
      core_sleep_o <= 1'b0;
    end else begin
      // A wake source wins over a retiring wait
      if (wake) begin
        in_wait_q <= 1'b0;
      end else if (wait_retire) begin
        in_wait_q <= 1'b1;
      end
      // Once asleep, stay asleep until woken
      core_sleep_o <= in_wait_q && !wake && (pipe_idle || core_sleep_o);
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------

  // Sleep only from inside the wait state
  a_sleep_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o |-> in_wait_q);

  // Dropping sleep while waiting means the wait ends next
  a_sleep_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(core_sleep_o) && in_wait_q |=> !in_wait_q);

endmodule

`default_nettype wire

//--- source/irq_sleep_top.sv
// Single clock and reset; software must set MSTATUS.MIE again after every taken interrupt
`timescale 1ns/1ps
`default_nettype none

module irq_sleep_top import irq_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Wishbone classic register port
  input  wire logic       wb_cyc_i,
  input  wire logic       wb_stb_i,
  input  wire logic       wb_we_i,
  input  wire wb_adr_t    wb_adr_i,
  input  wire wb_data_t   wb_dat_i,
  output wb_data_t        wb_dat_o,
  output logic            wb_ack_o,
  // Interrupt lines and core handshake
  input  wire irq_vec_t   irq_i,
  input  wire logic       irq_ready_i,
  output logic            irq_ack_o,
  output irq_id_t         irq_id_o,
  // Retirement stage
  input  wire logic       wb_instr_valid_i,
  input  wire instr_t     wb_instr_rdata_i,
  input  wire logic       wb_instr_err_i,
  input  wire logic       wb_kill_i,
  // Debug and pipeline state
  input  wire logic       debug_mode_i,
  input  wire logic       debug_req_i,
  input  wire logic       lsu_busy_i,
  input  wire logic [1:0] alignbuf_outstanding_i,
  output logic            core_sleep_o
);

  // ------------------------------------------------------------
  // Internal nets
  // ------------------------------------------------------------
  irq_vec_t mip;
  irq_vec_t mie;
  logic     mstatus_mie;
  logic     irq_wake;

  // Register block, clears global enable on ack
  irq_csr_regs csr_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .irq_i         (irq_i),
    .irq_ack_i     (irq_ack_o),
    .mip_o         (mip),
    .mie_o         (mie),
    .mstatus_mie_o (mstatus_mie)
  );

  irq_arbiter arb_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mip_i         (mip),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .irq_ready_i   (irq_ready_i),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o),
    .irq_wake_o    (irq_wake)
  );

  sleep_ctrl sleep_i (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .wb_instr_valid_i       (wb_instr_valid_i),
    .wb_instr_rdata_i       (wb_instr_rdata_i),
    .wb_instr_err_i         (wb_instr_err_i),
    .wb_kill_i              (wb_kill_i),
    .debug_mode_i           (debug_mode_i),
    .debug_req_i            (debug_req_i),
    .lsu_busy_i             (lsu_busy_i),
    .alignbuf_outstanding_i (alignbuf_outstanding_i),
    .irq_wake_i             (irq_wake),
    .core_sleep_o           (core_sleep_o)
  );

endmodule

`default_nettype wire

//--- sim/tb_irq_sleep.sv
// Directed checks only; assumes 2-cycle irq-to-ack and retire-to-sleep timing, run is time-limited
`timescale 1ns/1ps
`default_nettype none

module tb_irq_sleep import irq_pkg::*; ();

  // ------------------------------------------------------------
  // Constants and DUT signals
  // ------------------------------------------------------------
  localparam int CLK_PERIOD = 4;
  localparam int NUM_TESTS  = 6;
  // Budget per test in ns
  localparam int TEST_NS    = 400;
  localparam wb_data_t MSTATUS_ON = 32'h1 << MSTATUS_MIE_BIT;

  logic       clk_i;
  logic       rst_ni;
  logic       wb_cyc_i;
  logic       wb_stb_i;
  logic       wb_we_i;
  wb_adr_t    wb_adr_i;
  wb_data_t   wb_dat_i;
  wb_data_t   wb_dat_o;
  logic       wb_ack_o;
  irq_vec_t   irq_i;
  logic       irq_ready_i;
  logic       irq_ack_o;
  irq_id_t    irq_id_o;
  logic       wb_instr_valid_i;
  instr_t     wb_instr_rdata_i;
  logic       wb_instr_err_i;
  logic       wb_kill_i;
  logic       debug_mode_i;
  logic       debug_req_i;
  logic       lsu_busy_i;
  logic [1:0] alignbuf_outstanding_i;
  logic       core_sleep_o;

  int     mismatch_cnt = 0;
  int     other_cnt    = 0;
  integer seed         = 32'hf2fe9cb0;

  irq_sleep_top dut_i (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .wb_cyc_i               (wb_cyc_i),
    .wb_stb_i               (wb_stb_i),
    .wb_we_i                (wb_we_i),
    .wb_adr_i               (wb_adr_i),
    .wb_dat_i               (wb_dat_i),
    .wb_dat_o               (wb_dat_o),
    .wb_ack_o               (wb_ack_o),
    .irq_i                  (irq_i),
    .irq_ready_i            (irq_ready_i),
    .irq_ack_o              (irq_ack_o),
    .irq_id_o               (irq_id_o),
    .wb_instr_valid_i       (wb_instr_valid_i),
    .wb_instr_rdata_i       (wb_instr_rdata_i),
    .wb_instr_err_i         (wb_instr_err_i),
    .wb_kill_i              (wb_kill_i),
    .debug_mode_i           (debug_mode_i),
    .debug_req_i            (debug_req_i),
    .lsu_busy_i             (lsu_busy_i),
    .alignbuf_outstanding_i (alignbuf_outstanding_i),
    .core_sleep_o           (core_sleep_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Compare tasks and reference model
  // ------------------------------------------------------------
  task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input irq_id_t exp, input irq_id_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // Priority rule: 31 down to 16, then 11, 3, 7
  function automatic irq_id_t expected_winner(input irq_vec_t pend);
    bit      found;
    irq_id_t id;
    found = 1'b0;
    id    = '0;
    for (int i = 31; i >= 16; i--) begin
      if (!found && pend[i[4:0]]) begin
        found = 1'b1;
        id    = irq_id_t'(i);
      end
    end
    if (!found && pend[11]) begin
      found = 1'b1;
      id    = 5'd11;
    end
    if (!found && pend[3]) begin
      found = 1'b1;
      id    = 5'd3;
    end
    if (!found && pend[7]) begin
      id    = 5'd7;
    end
    return id;
  endfunction

  function automatic irq_vec_t line_bit(input int n);
    return irq_vec_t'(1) << n;
  endfunction

  // ------------------------------------------------------------
  // Bus and pipeline helpers
  // ------------------------------------------------------------
  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_data_t wdata,
                           output wb_data_t rdata);
    bit got_ack;
    got_ack = 1'b0;
    rdata   = '0;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= wdata;
    // Read data only valid alongside ack
    for (int n = 0; n < 4 && !got_ack; n++) begin
      @(negedge clk_i);
      if (wb_ack_o) begin
        got_ack = 1'b1;
        rdata   = wb_dat_o;
      end
    end
    if (!got_ack) begin
      other_cnt++;
      $display("Bus access to address %h got no acknowledge within 4 cycles", adr);
    end
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
    wb_data_t discard;
    bus_cycle(1'b1, adr, data, discard);
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  task automatic wait_for_ack(input int max_cycles, output bit seen, output irq_id_t id);
    seen = 1'b0;
    id   = '0;
    for (int n = 0; n < max_cycles && !seen; n++) begin
      @(negedge clk_i);
      if (irq_ack_o) begin
        seen = 1'b1;
        id   = irq_id_o;
      end
    end
    if (!seen) begin
      other_cnt++;
      $display("No interrupt acknowledge within %0d cycles at %0t ns", max_cycles, $time);
    end
  endtask

  task automatic expect_no_ack(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_bit("irq_ack_o", 1'b0, irq_ack_o);
    end
  endtask

  task automatic expect_no_sleep(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_bit("core_sleep_o", 1'b0, core_sleep_o);
    end
  endtask

  // One-cycle retirement at the write-back stage
  task automatic retire(input instr_t instr, input logic err, input logic kill);
    @(posedge clk_i);
    wb_instr_valid_i <= 1'b1;
    wb_instr_rdata_i <= instr;
    wb_instr_err_i   <= err;
    wb_kill_i        <= kill;
    @(posedge clk_i);
    wb_instr_valid_i <= 1'b0;
    wb_instr_rdata_i <= '0;
    wb_instr_err_i   <= 1'b0;
    wb_kill_i        <= 1'b0;
  endtask

  // Wait state one cycle after retirement, sleep one cycle later
  task automatic enter_sleep(input instr_t instr);
    retire(instr, 1'b0, 1'b0);
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b0, core_sleep_o);
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b1, core_sleep_o);
  endtask

  // MIP lags irq_i by a cycle, so sleep drops two cycles after the line
  task automatic wake_by_irq(input int line);
    @(posedge clk_i);
    irq_i <= line_bit(line);
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b1, core_sleep_o);
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b1, core_sleep_o);
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b0, core_sleep_o);
    // Global enable is clear here
    check_bit("irq_ack_o", 1'b0, irq_ack_o);
    @(posedge clk_i);
    irq_i <= '0;
    idle(2);
  endtask

  task automatic wake_by_debug();
    @(posedge clk_i);
    debug_req_i <= 1'b1;
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b1, core_sleep_o);
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b0, core_sleep_o);
    @(posedge clk_i);
    debug_req_i <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic reset_values();
    wb_data_t rd;
    wb_read(ADR_MIE, rd);
    check_word("MIE", '0, rd);
    wb_read(ADR_MSTATUS, rd);
    check_word("MSTATUS", '0, rd);
    wb_read(ADR_MIP, rd);
    check_word("MIP", '0, rd);
    expect_no_ack(3);
    expect_no_sleep(3);
  endtask

  task automatic register_access();
    wb_data_t rd;
    wb_write(ADR_MIE, 32'hffff_ffff);
    wb_read(ADR_MIE, rd);
    check_word("MIE", VALID_IRQ_MASK, rd);
    wb_write(ADR_MSTATUS, 32'hffff_ffff);
    wb_read(ADR_MSTATUS, rd);
    check_word("MSTATUS", MSTATUS_ON, rd);
    wb_write(ADR_MSTATUS, '0);
    wb_read(ADR_MSTATUS, rd);
    check_word("MSTATUS", '0, rd);
  endtask

  task automatic pending_readback();
    irq_vec_t lines;
    wb_data_t rd;
    lines = $random(seed);
    @(posedge clk_i);
    irq_i <= lines;
    idle(2);
    wb_read(ADR_MIP, rd);
    check_word("MIP", lines & VALID_IRQ_MASK, rd);
    @(posedge clk_i);
    irq_i <= '0;
    idle(2);
  endtask

  task automatic arbitration_random();
    irq_vec_t pend;
    wb_data_t rd;
    irq_id_t  id;
    bit       seen;
    @(posedge clk_i);
    irq_ready_i <= 1'b1;
    for (int k = 0; k < 8; k++) begin
      // Reserved bits stay in the stimulus to exercise the mask
      pend = $random(seed);
      // Odd sets drop the fast lines so 11, 3 and 7 compete
      if (k[0]) begin
        pend = (pend & 32'h0000_ffff) | line_bit(7);
      end
      // Every fourth set leaves line 3 against line 7
      if (k[1:0] == 2'b11) begin
        pend = (pend & ~line_bit(11)) | line_bit(3);
      end
      if ((pend & VALID_IRQ_MASK) == '0) begin
        pend = pend | line_bit(3);
      end
      wb_write(ADR_MSTATUS, MSTATUS_ON);
      @(posedge clk_i);
      irq_i <= pend;
      wait_for_ack(6, seen, id);
      if (seen) begin
        check_id("irq_id_o", expected_winner(pend & VALID_IRQ_MASK), id);
      end
      // Line still pending, cleared enable must block a second pulse
      expect_no_ack(4);
      @(posedge clk_i);
      irq_i <= '0;
      wb_read(ADR_MSTATUS, rd);
      check_word("MSTATUS", '0, rd);
    end
  endtask

  task automatic masked_requests();
    wb_data_t rd;
    irq_id_t  id;
    bit       seen;
    // Line not enabled in MIE
    wb_write(ADR_MIE, line_bit(3));
    wb_write(ADR_MSTATUS, MSTATUS_ON);
    @(posedge clk_i);
    irq_i <= line_bit(11);
    expect_no_ack(10);
    @(posedge clk_i);
    irq_i <= '0;
    // Global enable clear
    wb_write(ADR_MIE, 32'hffff_ffff);
    wb_write(ADR_MSTATUS, '0);
    @(posedge clk_i);
    irq_i <= line_bit(7);
    expect_no_ack(10);
    @(posedge clk_i);
    irq_i <= '0;
    // Core not ready, then released
    @(posedge clk_i);
    irq_ready_i <= 1'b0;
    wb_write(ADR_MSTATUS, MSTATUS_ON);
    @(posedge clk_i);
    irq_i <= line_bit(16);
    expect_no_ack(10);
    @(posedge clk_i);
    irq_ready_i <= 1'b1;
    wait_for_ack(4, seen, id);
    if (seen) begin
      check_id("irq_id_o", 5'd16, id);
    end
    @(posedge clk_i);
    irq_i <= '0;
    wb_read(ADR_MSTATUS, rd);
    check_word("MSTATUS", '0, rd);
  endtask

  task automatic sleep_and_wake();
    idle(2);
    enter_sleep(WFI_INSTR);
    wake_by_irq(18);
    enter_sleep(WFE_INSTR);
    wake_by_irq(11);
    // Faulty retirements never reach the wait state
    retire(WFI_INSTR, 1'b1, 1'b0);
    expect_no_sleep(6);
    retire(WFI_INSTR, 1'b0, 1'b1);
    expect_no_sleep(6);
    // Busy load/store unit holds sleep off
    @(posedge clk_i);
    lsu_busy_i <= 1'b1;
    retire(WFI_INSTR, 1'b0, 1'b0);
    expect_no_sleep(6);
    @(posedge clk_i);
    lsu_busy_i <= 1'b0;
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b0, core_sleep_o);
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b1, core_sleep_o);
    wake_by_irq(3);
    enter_sleep(WFI_INSTR);
    wake_by_debug();
  endtask

  // ------------------------------------------------------------
  // Sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    rst_ni                 = 1'b0;
    wb_cyc_i               = 1'b0;
    wb_stb_i               = 1'b0;
    wb_we_i                = 1'b0;
    wb_adr_i               = '0;
    wb_dat_i               = '0;
    irq_i                  = '0;
    irq_ready_i            = 1'b0;
    wb_instr_valid_i       = 1'b0;
    wb_instr_rdata_i       = '0;
    wb_instr_err_i         = 1'b0;
    wb_kill_i              = 1'b0;
    debug_mode_i           = 1'b0;
    debug_req_i            = 1'b0;
    lsu_busy_i             = 1'b0;
    alignbuf_outstanding_i = 2'd0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    reset_values();
    register_access();
    pending_readback();
    arbitration_random();
    masked_requests();
    sleep_and_wake();
    $display("Run complete: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * TEST_NS);
    $display("Watchdog expired after %0d ns, tests did not finish", NUM_TESTS * TEST_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
source/irq_pkg.sv
source/irq_csr_regs.sv
source/irq_arbiter.sv
source/sleep_ctrl.sv
source/irq_sleep_top.sv
sim/tb_irq_sleep.sv

//--- Makefile
# Verilator flow for the interrupt and sleep controller
TOP = tb_irq_sleep

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

# Pass or fail is taken from the log, not the simulator exit code
run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q -F -x "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log
